/* rtl/apb_pkg.sv */
// apb register interface definitions
package apb_pkg;

  // request from the bus master
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  // response back to the master
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // register map
  localparam logic [3:0] reg_ctrl_addr   = 4'd0;
  localparam logic [3:0] reg_status_addr = 4'd4;

  // ctrl register bits
  localparam int ctrl_cap_en_bit  = 0;
  localparam int ctrl_swap_bit    = 1;
  localparam int ctrl_pattern_bit = 2;

endpackage

/* rtl/cam_capture.sv */
// camera pixel capture
`timescale 1ns/1ps

module cam_capture #(
  parameter int img_cols = 16,
  parameter int img_rows = 12
) (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  video_pkg::cam_bus_t                  cam,
  input  logic                                 cap_en,
  input  logic                                 swap_rb,
  output logic                                 we,
  output logic [$clog2(img_cols*img_rows)-1:0] waddr,
  output video_pkg::pix_t                      wdata,
  output logic                                 frame_done
);
  import video_pkg::*;

  localparam int depth = img_cols * img_rows;
  localparam int aw    = $clog2(depth);

  typedef enum logic [1:0] {
    wait_frame,
    first_byte,
    second_byte
  } cap_state_t;

  cap_state_t   state;
  // pin history, pclk is only edge-detected inside clk
  logic         pclk_q;
  logic         vsync_q;
  logic [7:0]   hi_byte;
  // one extra bit so the count can sit at depth once the frame is full
  logic [aw:0]  pix_cnt;
  logic         pclk_rise;
  logic         vsync_rise;
  logic         byte_stb;
  logic         hi_stb;
  logic         lo_stb;
  logic         in_range;

  assign pclk_rise  = cam.pclk & ~pclk_q;
  assign vsync_rise = cam.vsync & ~vsync_q;
  // a byte counts only while href frames the line
  assign byte_stb   = pclk_rise & cam.href;
  // new frame start overrides any byte in flight
  assign hi_stb     = byte_stb && !vsync_rise && (state == first_byte);
  assign lo_stb     = byte_stb && !vsync_rise && (state == second_byte);
  assign in_range   = pix_cnt < (aw+1)'(depth);

  // control: fsm, edge history, address count, strobes
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= wait_frame;
      pclk_q     <= 1'b0;
      vsync_q    <= 1'b0;
      pix_cnt    <= '0;
      we         <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      pclk_q     <= cam.pclk;
      vsync_q    <= cam.vsync;
      // counted even with capture off, status reports every frame
      frame_done <= vsync_rise;
      we         <= 1'b0;
      if (vsync_rise) begin
        state   <= first_byte;
        pix_cnt <= '0;
      end else begin
        case (state)
          first_byte: begin
            if (hi_stb) state <= second_byte;
          end
          second_byte: begin
            if (!cam.href) begin
              // line ended mid pair, drop the half pixel
              state <= first_byte;
            end else if (lo_stb) begin
              state <= first_byte;
              we    <= cap_en && in_range;
              // saturate, overflow pixels are dropped
              if (in_range) pix_cnt <= pix_cnt + 1'b1;
            end
          end
          default: state <= wait_frame;
        endcase
      end
    end
  end

  // payload: high byte and the assembled write
  always_ff @(posedge clk) begin
    if (hi_stb) hi_byte <= cam.data;
    if (lo_stb) begin
      wdata <= rgb565_to_pix(hi_byte, cam.data, swap_rb);
      waddr <= pix_cnt[aw-1:0];
    end
  end

  // writes never leave the frame
  a_waddr_range: assert property (@(posedge clk) disable iff (!arst_n)
    we |-> (waddr < depth));

endmodule

/* rtl/cam_regs.sv */
// camera control registers
`timescale 1ns/1ps

module cam_regs (
  input  logic              clk,
  input  logic              arst_n,
  input  apb_pkg::apb_req_t apb_req,
  output apb_pkg::apb_rsp_t apb_rsp,
  input  logic              frame_done,
  output logic              cap_en,
  output logic              swap_rb,
  output logic              pattern
);
  import apb_pkg::*;

  logic [2:0] ctrl;
  logic [7:0] frame_cnt;
  logic       access;
  logic       addr_ok;

  // access phase, pready is tied high so no wait states
  assign access  = apb_req.psel & apb_req.penable;
  assign addr_ok = (apb_req.paddr == reg_ctrl_addr) || (apb_req.paddr == reg_status_addr);

  assign cap_en  = ctrl[ctrl_cap_en_bit];
  assign swap_rb = ctrl[ctrl_swap_bit];
  assign pattern = ctrl[ctrl_pattern_bit];

  // ctrl write at the access edge, status is read only
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      // capture running by default
      ctrl <= 3'b001;
    end else if (access && apb_req.pwrite && (apb_req.paddr == reg_ctrl_addr)) begin
      ctrl <= apb_req.pwdata[2:0];
    end
  end

  // received frames, wraps at 256
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      frame_cnt <= '0;
    end else if (frame_done) begin
      frame_cnt <= frame_cnt + 1'b1;
    end
  end

  // read mux, unmapped addresses read zero
  always_comb begin
    apb_rsp.prdata = '0;
    case (apb_req.paddr)
      reg_ctrl_addr:   apb_rsp.prdata = {29'd0, ctrl};
      reg_status_addr: apb_rsp.prdata = {24'd0, frame_cnt};
      default:         apb_rsp.prdata = '0;
    endcase
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = access && !addr_ok;
  end

  // enable phase always follows a setup phase
  a_apb_setup: assert property (@(posedge clk) disable iff (!arst_n)
    apb_req.penable |-> $past(apb_req.psel));

endmodule

/* rtl/cam_vga_top.sv */
// camera to display top level
`timescale 1ns/1ps

module cam_vga_top #(
  parameter int img_cols = 16,
  parameter int img_rows = 12,
  parameter int h_total  = 24,
  parameter int v_total  = 16
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  video_pkg::cam_bus_t  cam,
  input  apb_pkg::apb_req_t    apb_req,
  output apb_pkg::apb_rsp_t    apb_rsp,
  output video_pkg::vid_sync_t vid_sync,
  output video_pkg::pix_t      vid_pix
);
  import video_pkg::*;

  localparam int aw    = $clog2(img_cols * img_rows);
  localparam int col_w = $clog2(h_total);
  localparam int row_w = $clog2(v_total);

  // register controls
  logic             cap_en;
  logic             swap_rb;
  logic             pattern;
  logic             frame_done;
  // capture write port
  logic             we;
  logic [aw-1:0]    waddr;
  pix_t             wdata;
  // display read port
  logic [aw-1:0]    raddr;
  pix_t             rdata;
  // raster position
  logic [col_w-1:0] col;
  logic [row_w-1:0] row;
  vid_sync_t        sync;

  cam_regs u_regs (
    .clk        (clk),
    .arst_n     (arst_n),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .frame_done (frame_done),
    .cap_en     (cap_en),
    .swap_rb    (swap_rb),
    .pattern    (pattern)
  );

  cam_capture #(.img_cols(img_cols), .img_rows(img_rows)) u_capture (
    .clk        (clk),
    .arst_n     (arst_n),
    .cam        (cam),
    .cap_en     (cap_en),
    .swap_rb    (swap_rb),
    .we         (we),
    .waddr      (waddr),
    .wdata      (wdata),
    .frame_done (frame_done)
  );

  frame_buffer #(.img_cols(img_cols), .img_rows(img_rows)) u_fb (
    .clk   (clk),
    .we    (we),
    .waddr (waddr),
    .wdata (wdata),
    .raddr (raddr),
    .rdata (rdata)
  );

  raster_timing #(
    .img_cols (img_cols),
    .img_rows (img_rows),
    .h_total  (h_total),
    .v_total  (v_total)
  ) u_timing (
    .clk    (clk),
    .arst_n (arst_n),
    .col    (col),
    .row    (row),
    .sync   (sync)
  );

  raster_display #(
    .img_cols (img_cols),
    .img_rows (img_rows),
    .col_w    (col_w),
    .row_w    (row_w)
  ) u_display (
    .clk      (clk),
    .arst_n   (arst_n),
    .col      (col),
    .row      (row),
    .sync     (sync),
    .pattern  (pattern),
    .raddr    (raddr),
    .rdata    (rdata),
    .vid_sync (vid_sync),
    .vid_pix  (vid_pix)
  );

endmodule

/* rtl/frame_buffer.sv */
// dual port frame memory
`timescale 1ns/1ps

module frame_buffer #(
  parameter int img_cols = 16,
  parameter int img_rows = 12
) (
  input  logic                                 clk,
  input  logic                                 we,
  input  logic [$clog2(img_cols*img_rows)-1:0] waddr,
  input  video_pkg::pix_t                      wdata,
  input  logic [$clog2(img_cols*img_rows)-1:0] raddr,
  output video_pkg::pix_t                      rdata
);
  import video_pkg::*;

  localparam int depth = img_cols * img_rows;

  // one word per pixel, row major
  pix_t mem [depth];

  // capture side
  always_ff @(posedge clk) begin
    if (we) mem[waddr] <= wdata;
  end

  // display side, one cycle read latency
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

/* rtl/raster_display.sv */
// raster pixel output stage
`timescale 1ns/1ps

module raster_display #(
  parameter int img_cols = 16,
  parameter int img_rows = 12,
  parameter int col_w    = 5,
  parameter int row_w    = 4
) (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  logic [col_w-1:0]                     col,
  input  logic [row_w-1:0]                     row,
  input  video_pkg::vid_sync_t                 sync,
  input  logic                                 pattern,
  output logic [$clog2(img_cols*img_rows)-1:0] raddr,
  input  video_pkg::pix_t                      rdata,
  output video_pkg::vid_sync_t                 vid_sync,
  output video_pkg::pix_t                      vid_pix
);
  import video_pkg::*;

  localparam int aw = $clog2(img_cols * img_rows);

  // stage 1, aligned with the buffer read
  vid_sync_t  sync_d1;
  logic [3:0] col_d1;
  logic [3:0] row_d1;

  // row major address, parked at 0 outside the active area
  always_comb begin
    raddr = '0;
    if (sync.de) raddr = aw'(row * img_cols + col);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_d1  <= '0;
      col_d1   <= '0;
      row_d1   <= '0;
      vid_sync <= '0;
      vid_pix  <= '0;
    end else begin
      sync_d1  <= sync;
      // pattern only needs the low nibble of the position
      col_d1   <= 4'(col);
      row_d1   <= 4'(row);
      // stage 2, output register
      vid_sync <= sync_d1;
      if (!sync_d1.de) begin
        // blanking is black
        vid_pix <= '0;
      end else if (pattern) begin
        vid_pix.r <= col_d1;
        vid_pix.g <= row_d1;
        vid_pix.b <= col_d1 ^ row_d1;
      end else begin
        vid_pix <= rdata;
      end
    end
  end

endmodule

/* rtl/raster_timing.sv */
// raster position timer
`timescale 1ns/1ps

module raster_timing #(
  parameter int img_cols = 16,
  parameter int img_rows = 12,
  parameter int h_total  = 24,
  parameter int v_total  = 16
) (
  input  logic                         clk,
  input  logic                         arst_n,
  output logic [$clog2(h_total)-1:0]   col,
  output logic [$clog2(v_total)-1:0]   row,
  output video_pkg::vid_sync_t         sync
);
  import video_pkg::*;

  localparam int col_w = $clog2(h_total);
  localparam int row_w = $clog2(v_total);

  logic [col_w-1:0] col_nxt;
  logic [row_w-1:0] row_nxt;

  // next position, column wraps first and carries into the row
  always_comb begin
    col_nxt = col + 1'b1;
    row_nxt = row;
    if (col == col_w'(h_total - 1)) begin
      col_nxt = '0;
      if (row == row_w'(v_total - 1)) begin
        row_nxt = '0;
      end else begin
        row_nxt = row + 1'b1;
      end
    end
  end

  // sync decoded from the next position so it lines up with col/row
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      col  <= '0;
      row  <= '0;
      sync <= '0;
    end else begin
      col        <= col_nxt;
      row        <= row_nxt;
      sync.de    <= (col_nxt < img_cols) && (row_nxt < img_rows);
      // four column hsync pulse right after the active area
      sync.hsync <= (col_nxt >= img_cols) && (col_nxt < img_cols + 4);
      // vsync on the last line of the frame
      sync.vsync <= (row_nxt == v_total - 1);
    end
  end

  a_pos_range: assert property (@(posedge clk) disable iff (!arst_n)
    (col < h_total) && (row < v_total));

endmodule

/* rtl/video_pkg.sv */
// video datapath types
package video_pkg;

  // stored and displayed pixel, rgb444
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } pix_t;

  // sync state of one raster position
  typedef struct packed {
    logic hsync;
    logic vsync;
    logic de;
  } vid_sync_t;

  // camera pin group, as seen from the sensor connector
  typedef struct packed {
    logic       vsync;
    logic       href;
    logic       pclk;
    logic [7:0] data;
  } cam_bus_t;

  // rgb565 byte pair to rgb444
  // hi = r5 g6[5:3], lo = g6[2:0] b5
  function automatic pix_t rgb565_to_pix(logic [7:0] hi, logic [7:0] lo, logic swap);
    pix_t p;
    p.r = hi[7:4];
    // upper four of the six green bits straddle the byte boundary
    p.g = {hi[2:0], lo[7]};
    p.b = lo[4:1];
    // optional red/blue exchange for sensors wired the other way
    if (swap) begin
      p.r = lo[4:1];
      p.b = hi[7:4];
    end
    return p;
  endfunction

endpackage

/* sim/tb_cam_vga.sv */
// camera to display testbench
`timescale 1ns/1ps

module tb_cam_vga;
  import video_pkg::*;
  import apb_pkg::*;

  localparam int img_cols = 16;
  localparam int img_rows = 12;
  localparam int h_total  = 24;
  localparam int v_total  = 16;
  localparam int npix     = img_cols * img_rows;
  // idle clk cycles between camera lines
  localparam int line_gap = 4;
  // one camera frame is about 12 * (16*2*4 + 4) + 8 = 1600 cycles, three frames
  // plus four checks of up to two 384-cycle display frames is near 8000
  localparam int timeout_cycles = 20000;

  logic      clk;
  logic      arst_n;
  cam_bus_t  cam;
  apb_req_t  apb_req;
  apb_rsp_t  apb_rsp;
  vid_sync_t vid_sync;
  pix_t      vid_pix;

  // expected image, row major
  pix_t      exp_frame [npix];
  int        vs_rises;
  int        cycles;
  // request/done counters between the stimulus and the comparing process
  int        chk_req_cnt;
  int        chk_seen_cnt;
  int        chk_done_cnt;
  string     chk_name;
  logic      chk_pattern;
  logic      chk_run;
  logic      vsync_prev;
  int        pix_idx;
  pix_t      exp_pix;
  // clock edges seen since reset was released
  int        live_edges;
  vid_sync_t exp_sync;

  cam_vga_top #(
    .img_cols (img_cols),
    .img_rows (img_rows),
    .h_total  (h_total),
    .v_total  (v_total)
  ) DUT (
    .clk      (clk),
    .arst_n   (arst_n),
    .cam      (cam),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .vid_sync (vid_sync),
    .vid_pix  (vid_pix)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // rgb565 word to the stored rgb444 pixel
  function automatic pix_t ref_pix(input logic [15:0] w, input logic swap);
    pix_t p;
    // keep the upper four bits of r5 [15:11], g6 [10:5] and b5 [4:0]
    p.r = w[15:12];
    p.g = w[10:7];
    p.b = w[4:1];
    if (swap) begin
      p.r = w[4:1];
      p.b = w[15:12];
    end
    return p;
  endfunction

  // test pattern for a pixel index in the active area
  function automatic pix_t ref_pattern(input int idx);
    pix_t p;
    p.r = 4'(idx % img_cols);
    p.g = 4'(idx / img_cols);
    p.b = p.r ^ p.g;
    return p;
  endfunction

  // raster sync for a position counted from the top left corner
  function automatic vid_sync_t ref_sync(input int pos);
    vid_sync_t s;
    int        c;
    int        r;
    c       = pos % h_total;
    r       = (pos / h_total) % v_total;
    s.de    = (c < img_cols) && (r < img_rows);
    s.hsync = (c >= img_cols) && (c < img_cols + 4);
    s.vsync = (r == v_total - 1);
    return s;
  endfunction

  task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("FAILED %s expected %0h actual %0h", name, exp, act);
    $display("Test failed");
    $fatal(1);
  endtask

  // all bus tasks start and end right after a rising edge
  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b1;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= data;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(posedge clk);
    // slave never inserts wait states
    assert (apb_rsp.pready) else fail_value("apb write pready", 1, apb_rsp.pready);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b0;
    @(posedge clk);
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic err, output logic rdy);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b0;
    apb_req.paddr   <= addr;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(posedge clk);
    // access phase, response still reflects the held request
    data = apb_rsp.prdata;
    err  = apb_rsp.pslverr;
    rdy  = apb_rsp.pready;
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
    @(posedge clk);
  endtask

  task automatic check_reg(input string name, input logic [3:0] addr,
                           input logic [31:0] exp_data, input logic exp_err);
    logic [31:0] data;
    logic        err;
    logic        rdy;
    apb_read(addr, data, err, rdy);
    assert (rdy == 1'b1) else fail_value({name, " pready"}, 1, rdy);
    assert (err == exp_err) else fail_value({name, " pslverr"}, exp_err, err);
    assert (data == exp_data) else fail_value(name, exp_data, data);
  endtask

  // one camera byte, pclk low for two clk then high for two
  task automatic send_byte(input logic [7:0] b);
    cam.data <= b;
    cam.pclk <= 1'b0;
    repeat (2) @(posedge clk);
    cam.pclk <= 1'b1;
    repeat (2) @(posedge clk);
  endtask

  // vsync pulse then img_rows lines of random rgb565 pixels
  task automatic send_frame(input logic swap, input logic store);
    logic [15:0] word;
    cam.vsync <= 1'b1;
    repeat (4) @(posedge clk);
    cam.vsync <= 1'b0;
    vs_rises++;
    repeat (4) @(posedge clk);
    for (int r = 0; r < img_rows; r++) begin
      cam.href <= 1'b1;
      for (int c = 0; c < img_cols; c++) begin
        word = 16'($urandom);
        // frozen frames leave the expected image alone
        if (store) exp_frame[r*img_cols+c] = ref_pix(word, swap);
        send_byte(word[15:8]);
        send_byte(word[7:0]);
      end
      cam.href <= 1'b0;
      cam.pclk <= 1'b0;
      repeat (line_gap) @(posedge clk);
    end
  endtask

  // hand one display frame to the comparing process and wait for it
  task automatic check_frame(input string name, input logic use_pattern);
    int target;
    target      = chk_done_cnt + 1;
    chk_name    = name;
    chk_pattern = use_pattern;
    chk_req_cnt <= chk_req_cnt + 1;
    while (chk_done_cnt != target) @(posedge clk);
  endtask

  // comparing process, position counted in de pixels after vsync falls
  always @(posedge clk) begin
    // output sync trails the raster position by two clocks out of reset
    if (arst_n) begin
      if (live_edges <= 2) begin
        exp_sync = '0;
      end else begin
        exp_sync = ref_sync(live_edges - 2);
      end
      assert (vid_sync == exp_sync) else fail_value("raster sync", exp_sync, vid_sync);
      live_edges++;
    end
    if (chk_req_cnt != chk_seen_cnt && vsync_prev && !vid_sync.vsync) begin
      chk_seen_cnt = chk_req_cnt;
      chk_run      = 1'b1;
      pix_idx      = 0;
    end
    if (chk_run) begin
      if (vid_sync.de) begin
        exp_pix = chk_pattern ? ref_pattern(pix_idx) : exp_frame[pix_idx];
        assert (vid_pix == exp_pix) else fail_value(chk_name, exp_pix, vid_pix);
        pix_idx++;
        if (pix_idx == npix) begin
          chk_run = 1'b0;
          chk_done_cnt <= chk_done_cnt + 1;
        end
      end else begin
        // blanking must be black
        assert (vid_pix == '0) else fail_value({chk_name, " blank"}, 0, vid_pix);
      end
    end
    vsync_prev = vid_sync.vsync;
  end

  initial begin
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d clock cycles", timeout_cycles);
    $display("Test failed");
    $fatal(1);
  end

  initial begin
    arst_n       = 1'b0;
    cam          = '0;
    apb_req      = '0;
    vs_rises     = 0;
    chk_req_cnt  = 0;
    chk_seen_cnt = 0;
    chk_done_cnt = 0;
    chk_name     = "";
    chk_pattern  = 1'b0;
    chk_run      = 1'b0;
    vsync_prev   = 1'b0;
    pix_idx      = 0;
    live_edges   = 0;
    void'($urandom(28));
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);

    // register reset values and an unmapped read
    check_reg("reset ctrl", reg_ctrl_addr, 32'd1, 1'b0);
    check_reg("reset status", reg_status_addr, 32'd0, 1'b0);
    check_reg("unmapped read", 4'd8, 32'd0, 1'b1);

    // plain capture
    send_frame(1'b0, 1'b1);
    check_frame("capture", 1'b0);

    // red/blue swap
    apb_write(reg_ctrl_addr, 32'h3);
    send_frame(1'b1, 1'b1);
    check_frame("swap", 1'b0);

    // freeze, buffer keeps the swapped frame
    apb_write(reg_ctrl_addr, 32'h2);
    send_frame(1'b1, 1'b0);
    check_frame("freeze", 1'b0);

    // test pattern
    apb_write(reg_ctrl_addr, 32'h4);
    check_frame("pattern", 1'b1);

    // every vsync rise counts, frozen frames too
    check_reg("frame count", reg_status_addr, 32'(vs_rises % 256), 1'b0);

    $display("Test passed");
    $finish;
  end

endmodule

/* verilog.f */
rtl/video_pkg.sv
rtl/apb_pkg.sv
rtl/cam_capture.sv
rtl/raster_timing.sv
rtl/frame_buffer.sv
rtl/raster_display.sv
rtl/cam_regs.sv
rtl/cam_vga_top.sv
sim/tb_cam_vga.sv
